// ==== rtl/qq_consts.svh ====
`ifndef QQ_CONSTS_SVH
`define QQ_CONSTS_SVH

// Queue geometry shared by RTL and testbench

// Number of key slots in the sorted array
`define QQ_DEPTH 8

// Unsigned key width in bits
`define QQ_WIDTH 16

// Index and count width
// One bit wider than the slot address so a count of QQ_DEPTH fits
`define QQ_IDX_W 4

`endif

// ==== rtl/qq_pkg.sv ====
`default_nettype none

package qq_pkg;

  // Controller states
  // Enqueue walks fill -> compare -> (swap) -> inc ... -> tail write
  // Dequeue is a single shift cycle
  typedef enum logic [2:0] {
    idle        = 3'd0,
    fill_enq    = 3'd1,
    compare_enq = 3'd2,
    swap_enq    = 3'd3,
    cnt_inc     = 3'd4,
    write_tail  = 3'd5,
    deq_shift   = 3'd6
  } state_t;

  // Operation codes for the stimulus table
  typedef enum logic [1:0] {
    op_nop = 2'd0,
    op_enq = 2'd1,
    op_deq = 2'd2
  } op_t;

endpackage

`default_nettype wire

// ==== rtl/qq_ctrl_if.sv ====
`default_nettype none

// Control strobes from the sequencer to the datapath blocks
// All strobes are single-cycle levels, no handshake
interface qq_ctrl_if;

  // Load temp register from data_in
  logic temp_load;
  // Exchange temp register with slot at the walk index
  logic swap;
  // Walk index advance and clear
  logic idx_inc;
  logic idx_clr;
  // Write temp into slot at count, count up
  logic tail_we;
  // Slots move down by one, count down
  logic shift;

  modport ctrl (
    output temp_load, swap, idx_inc, idx_clr, tail_we, shift
  );

  // Storage only cares about data movement
  modport store (
    input temp_load, swap, tail_we, shift
  );

  // Index block tracks walk position and occupancy
  modport index (
    input idx_inc, idx_clr, tail_we, shift
  );

endinterface

`default_nettype wire

// ==== rtl/qq_store.sv ====
`default_nettype none

`include "qq_consts.svh"

module qq_store (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic [`QQ_WIDTH-1:0] data_in,
  input  wire logic [`QQ_IDX_W-1:0] idx,
  input  wire logic [`QQ_IDX_W-1:0] count,
  qq_ctrl_if.store                  ctl,
  output logic                      result,
  output logic      [`QQ_WIDTH-1:0] data_out,
  output logic                      out_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Sorted slots, slot 0 is the minimum
  logic [`QQ_WIDTH-1:0] slot [`QQ_DEPTH];
  // Key being carried along the walk
  logic [`QQ_WIDTH-1:0] temp;
  // Slot under the walk index
  logic [`QQ_WIDTH-1:0] sel;

  // Index mux over the occupied range
  // Index at or past depth reads as zero, only reached when done is set
  always_comb
  begin
    sel = '0;
    for (int i = 0; i < `QQ_DEPTH; i++)
    begin
      if (idx == `QQ_IDX_W'(i))
        sel = slot[i];
    end
  end

  // Strictly less so equal keys stay behind earlier arrivals
  assign result = temp < sel;

  // Temp register
  always_ff @(posedge clk)
  begin
    if (ctl.temp_load)
      temp <= data_in;
    else if (ctl.swap)
      temp <= sel;
  end

  // Slot array updates, at most one strobe per cycle
  always_ff @(posedge clk)
  begin
    if (ctl.shift)
    begin
      // Whole array moves down in one cycle
      for (int i = 0; i < `QQ_DEPTH - 1; i++)
        slot[i] <= slot[i+1];
    end
    else if (ctl.swap)
    begin
      for (int i = 0; i < `QQ_DEPTH; i++)
      begin
        if (idx == `QQ_IDX_W'(i))
          slot[i] <= temp;
      end
    end
    else if (ctl.tail_we)
    begin
      // First free slot is at count
      for (int i = 0; i < `QQ_DEPTH; i++)
      begin
        if (count == `QQ_IDX_W'(i))
          slot[i] <= temp;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Head output
  ////////////////////////////////////////////////////////////////////////////

  // Head copy follows every write into slot 0
  // Ready on the cycle the shift strobe fires
  always_ff @(posedge clk)
  begin
    if (rst)
      data_out <= '0;
    else if (ctl.shift && count > `QQ_IDX_W'(1))
      data_out <= slot[1];
    else if (ctl.swap && idx == '0)
      data_out <= temp;
    else if (ctl.tail_we && count == '0)
      data_out <= temp;
  end

  // One-cycle valid pulse with the shift
  assign out_valid = ctl.shift;

  // Walk never swaps beyond the occupied slots
  assert property (@(posedge clk) disable iff (rst)
    ctl.swap |-> (idx < count))
    else $error("swap with idx %0d at or past count %0d", idx, count);

endmodule

`default_nettype wire

// ==== rtl/qq_index.sv ====
`default_nettype none

`include "qq_consts.svh"

module qq_index (
  input  wire logic                 clk,
  input  wire logic                 rst,
  qq_ctrl_if.index                  ctl,
  output logic      [`QQ_IDX_W-1:0] idx,
  output logic      [`QQ_IDX_W-1:0] count,
  output logic                      done,
  output logic                      full,
  output logic                      empty
);

  // Walk index
  // Cleared at the start of every enqueue
  always_ff @(posedge clk)
  begin
    if (rst)
      idx <= '0;
    else if (ctl.idx_clr)
      idx <= '0;
    else if (ctl.idx_inc)
      idx <= idx + `QQ_IDX_W'(1);
  end

  // Occupancy count
  // Up on tail write, down on shift
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (ctl.tail_we)
      count <= count + `QQ_IDX_W'(1);
    else if (ctl.shift)
      count <= count - `QQ_IDX_W'(1);
  end

  // Walk finished once every occupied slot was compared
  assign done  = idx == count;

  // Occupancy flags
  assign full  = count == `QQ_IDX_W'(`QQ_DEPTH);
  assign empty = count == '0;

  // Count stays within the array
  assert property (@(posedge clk) disable iff (rst)
    count <= `QQ_IDX_W'(`QQ_DEPTH))
    else $error("count %0d exceeds depth", count);

  // Controller must not write a tail into a full array or shift an empty one
  assert property (@(posedge clk) disable iff (rst)
    (ctl.tail_we |-> !full) and (ctl.shift |-> !empty))
    else $error("tail write while full or shift while empty");

endmodule

`default_nettype wire

// ==== rtl/qq_control.sv ====
`default_nettype none

module qq_control (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic enq,
  input  wire logic deq,
  input  wire logic result,
  input  wire logic done,
  input  wire logic full,
  input  wire logic empty,
  qq_ctrl_if.ctrl   ctl,
  output logic      busy
);

  ////////////////////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////////////////////

  qq_pkg::state_t state;
  qq_pkg::state_t next;

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= qq_pkg::idle;
    else
      state <= next;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next = state;
    case (state)
      qq_pkg::idle:
      begin
        // Dequeue has priority, the enqueue is dropped
        if (deq)
        begin
          if (!empty)
            next = qq_pkg::deq_shift;
        end
        else if (enq && !full)
          next = qq_pkg::fill_enq;
      end

      // Temp loaded, index cleared
      qq_pkg::fill_enq:
        next = qq_pkg::compare_enq;

      qq_pkg::compare_enq:
      begin
        // Past the last occupied slot, temp goes to the tail
        if (done)
          next = qq_pkg::write_tail;
        else if (result)
          next = qq_pkg::swap_enq;
        else
          next = qq_pkg::cnt_inc;
      end

      // Swap is always followed by the index step
      qq_pkg::swap_enq:
        next = qq_pkg::cnt_inc;

      qq_pkg::cnt_inc:
        next = qq_pkg::compare_enq;

      qq_pkg::write_tail:
        next = qq_pkg::idle;

      qq_pkg::deq_shift:
        next = qq_pkg::idle;

      default:
        next = qq_pkg::idle;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobe decode
  ////////////////////////////////////////////////////////////////////////////

  // Moore outputs, one state per datapath action
  assign ctl.temp_load = state == qq_pkg::fill_enq;
  assign ctl.idx_clr   = state == qq_pkg::fill_enq;
  assign ctl.swap      = state == qq_pkg::swap_enq;
  assign ctl.idx_inc   = state == qq_pkg::cnt_inc;
  assign ctl.tail_we   = state == qq_pkg::write_tail;
  assign ctl.shift     = state == qq_pkg::deq_shift;

  // Busy covers the whole operation after the request cycle
  assign busy = state != qq_pkg::idle;

  // Datapath is quiet whenever the sequencer is idle
  assert property (@(posedge clk) disable iff (rst)
    (state == qq_pkg::idle) |->
      !(ctl.temp_load || ctl.swap || ctl.idx_inc ||
        ctl.idx_clr || ctl.tail_we || ctl.shift))
    else $error("strobe active in idle");

endmodule

`default_nettype wire

// ==== rtl/quickq_top.sv ====
`default_nettype none

`include "qq_consts.svh"

module quickq_top (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 enq,
  input  wire logic                 deq,
  input  wire logic [`QQ_WIDTH-1:0] data_in,
  output logic      [`QQ_WIDTH-1:0] data_out,
  output logic                      out_valid,
  output logic                      busy,
  output logic      [`QQ_IDX_W-1:0] count,
  output logic                      full,
  output logic                      empty
);

  // Sequencer to datapath strobes
  qq_ctrl_if ctl_if ();

  // Datapath results back to the sequencer
  logic                 result;
  logic                 done;
  // Walk position into storage
  logic [`QQ_IDX_W-1:0] idx;

  qq_control u_control (
    .clk    (clk),
    .rst    (rst),
    .enq    (enq),
    .deq    (deq),
    .result (result),
    .done   (done),
    .full   (full),
    .empty  (empty),
    .ctl    (ctl_if),
    .busy   (busy)
  );

  qq_store u_store (
    .clk       (clk),
    .rst       (rst),
    .data_in   (data_in),
    .idx       (idx),
    .count     (count),
    .ctl       (ctl_if),
    .result    (result),
    .data_out  (data_out),
    .out_valid (out_valid)
  );

  qq_index u_index (
    .clk   (clk),
    .rst   (rst),
    .ctl   (ctl_if),
    .idx   (idx),
    .count (count),
    .done  (done),
    .full  (full),
    .empty (empty)
  );

endmodule

`default_nettype wire

// ==== verif/qq_checker.sv ====
`default_nettype none

`include "qq_consts.svh"

module qq_checker (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 enq,
  input  wire logic                 deq,
  input  wire logic [`QQ_WIDTH-1:0] data_in,
  input  wire logic [`QQ_WIDTH-1:0] data_out,
  input  wire logic                 out_valid,
  input  wire logic                 busy,
  input  wire logic [`QQ_IDX_W-1:0] count,
  input  wire logic                 full,
  input  wire logic                 empty,
  input  wire logic                 entry_done,
  input  wire logic [7:0]           entry_num,
  input  wire logic [1:0]           entry_op,
  input  wire logic [`QQ_IDX_W-1:0] entry_count,
  output int                        err_count,
  output int                        test_count,
  output int                        pass_count
);

  // Stimulus copies taken on the rising edge
  logic                 cap_rst = 1'b1;
  logic                 cap_enq;
  logic                 cap_deq;
  logic                 cap_done;
  logic [`QQ_WIDTH-1:0] cap_data;
  logic [7:0]           cap_num;
  logic [1:0]           cap_op;
  logic [`QQ_IDX_W-1:0] cap_count;

  // Reference queue, front is the minimum
  logic [`QQ_WIDTH-1:0] model [$];
  bit                   reset_seen;
  // Dequeue accepted on the last rising edge
  bit                   deq_taken;
  int                   errs_before;
  string                where;

  always @(posedge clk)
  begin
    cap_rst   <= rst;
    cap_enq   <= enq;
    cap_deq   <= deq;
    cap_done  <= entry_done;
    cap_data  <= data_in;
    cap_num   <= entry_num;
    cap_op    <= entry_op;
    cap_count <= entry_count;
  end

  task automatic compare_field(input string name, input logic [`QQ_WIDTH-1:0] want,
                               input logic [`QQ_WIDTH-1:0] got);
    if (got !== want)
    begin
      $display("Fail %s: %s expected %0h, got %0h", where, name, want, got);
      err_count++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("Error %s: %s", where, what);
    err_count++;
  endtask

  // Sorted insert, equal keys go behind earlier ones
  task automatic add_key(input logic [`QQ_WIDTH-1:0] key);
    int pos;
    pos = model.size();
    for (int i = model.size() - 1; i >= 0; i--)
    begin
      if (key < model[i])
        pos = i;
    end
    // Full queue drops the key
    if (model.size() < `QQ_DEPTH)
      model.insert(pos, key);
  endtask

  task automatic close_test(input string name);
    test_count++;
    if (err_count == errs_before)
    begin
      pass_count++;
      $display("Test %s passed", name);
    end
    else
      $display("Test %s failed with %0d errors", name, err_count - errs_before);
    errs_before = err_count;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reset();
    where = "reset";
    compare_field("count", '0, 16'(count));
    compare_field("empty", 16'(1'b1), 16'(empty));
    compare_field("full", '0, 16'(full));
    compare_field("busy", '0, 16'(busy));
    compare_field("out_valid", '0, 16'(out_valid));
    compare_field("data_out", '0, data_out);
    close_test(where);
    reset_seen = 1'b1;
  endtask

  // Head must be the smallest key at the time of the request
  // Valid is due on the cycle right after the accepting edge
  task automatic check_head();
    logic [`QQ_WIDTH-1:0] head;
    head = model.pop_front();
    if (!out_valid)
      report_problem("no out_valid on the cycle after an accepted dequeue");
    else
      compare_field("data_out", head, data_out);
  endtask

  task automatic check_entry();
    qq_pkg::op_t op;
    op = qq_pkg::op_t'(cap_op);
    where = $sformatf("test %0d (%s)", cap_num, op.name());
    compare_field("count", 16'(cap_count), 16'(count));
    compare_field("full", 16'(cap_count == `QQ_IDX_W'(`QQ_DEPTH)), 16'(full));
    compare_field("empty", 16'(cap_count == '0), 16'(empty));
    // Table and reference model must agree on occupancy
    if (model.size() != int'(cap_count))
      report_problem($sformatf("reference holds %0d keys, table expects %0d",
                               model.size(), cap_count));
    close_test(where);
  endtask

  // Outputs sampled on the falling edge
  always @(negedge clk)
  begin
    if (cap_rst)
    begin
      model.delete();
      err_count   = 0;
      test_count  = 0;
      pass_count  = 0;
      errs_before = 0;
      reset_seen  = 1'b0;
      deq_taken   = 1'b0;
    end
    else
    begin
      if (!reset_seen)
        check_reset();
      where = $sformatf("test %0d", cap_num);
      deq_taken = 1'b0;
      // Request taken in idle, dequeue wins
      if (cap_deq)
      begin
        deq_taken = model.size() > 0;
        if (deq_taken)
          check_head();
        compare_field("busy", 16'(deq_taken), 16'(busy));
      end
      else if (cap_enq)
      begin
        // Busy rises only for a key that fits
        compare_field("busy", 16'(model.size() < `QQ_DEPTH), 16'(busy));
        add_key(cap_data);
      end
      // Any other pulse is spurious or held too long
      if (out_valid && !deq_taken)
        report_problem("out_valid pulsed with no dequeue accepted");
      if (cap_done)
        check_entry();
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
`default_nettype none

`include "qq_consts.svh"

module tb_top;

  // DUT ports
  logic                 clk = 1'b0;
  logic                 rst;
  logic                 enq;
  logic                 deq;
  logic [`QQ_WIDTH-1:0] data_in;
  logic [`QQ_WIDTH-1:0] data_out;
  logic                 out_valid;
  logic                 busy;
  logic [`QQ_IDX_W-1:0] count;
  logic                 full;
  logic                 empty;

  // Current row, handed to the checker
  logic                 entry_done;
  logic [7:0]           entry_num;
  qq_pkg::op_t          entry_op;
  logic [`QQ_IDX_W-1:0] entry_count;

  int                   errs;
  int                   tests;
  int                   passes;

  // Stimulus table, one row per operation
  qq_pkg::op_t          tbl_op [$];
  logic [`QQ_WIDTH-1:0] tbl_key [$];
  logic [`QQ_IDX_W-1:0] tbl_count [$];

  integer               seed;
  int                   cycles = 0;
  int                   cycle_limit = 0;

  always #50 clk = ~clk;

  quickq_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .enq       (enq),
    .deq       (deq),
    .data_in   (data_in),
    .data_out  (data_out),
    .out_valid (out_valid),
    .busy      (busy),
    .count     (count),
    .full      (full),
    .empty     (empty)
  );

  qq_checker u_check (
    .clk         (clk),
    .rst         (rst),
    .enq         (enq),
    .deq         (deq),
    .data_in     (data_in),
    .data_out    (data_out),
    .out_valid   (out_valid),
    .busy        (busy),
    .count       (count),
    .full        (full),
    .empty       (empty),
    .entry_done  (entry_done),
    .entry_num   (entry_num),
    .entry_op    (entry_op),
    .entry_count (entry_count),
    .err_count   (errs),
    .test_count  (tests),
    .pass_count  (passes)
  );

  task automatic add_row(input qq_pkg::op_t op, input logic [`QQ_WIDTH-1:0] key,
                         input logic [`QQ_IDX_W-1:0] cnt);
    tbl_op.push_back(op);
    tbl_key.push_back(key);
    tbl_count.push_back(cnt);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [31:0] r;
    logic [19:0] pat;
    int          level;
    add_row(qq_pkg::op_nop, '0, 4'd0);
    // Descending keys, every compare swaps
    for (int i = 0; i < `QQ_DEPTH; i++)
      add_row(qq_pkg::op_enq, 16'(16'h0900 - i * 256), 4'(i + 1));
    // Ninth key into a full queue is dropped
    add_row(qq_pkg::op_enq, 16'h0001, 4'(`QQ_DEPTH));
    for (int i = 0; i < `QQ_DEPTH; i++)
      add_row(qq_pkg::op_deq, '0, 4'(`QQ_DEPTH - 1 - i));
    // Dequeue from empty
    add_row(qq_pkg::op_deq, '0, 4'd0);
    // Ascending keys, walk without swaps
    for (int i = 0; i < 5; i++)
      add_row(qq_pkg::op_enq, 16'(16'h0010 + i * 16), 4'(i + 1));
    for (int i = 0; i < 5; i++)
      add_row(qq_pkg::op_deq, '0, 4'(4 - i));
    // Duplicates mixed in
    add_row(qq_pkg::op_enq, 16'h0300, 4'd1);
    add_row(qq_pkg::op_enq, 16'h0100, 4'd2);
    add_row(qq_pkg::op_enq, 16'h0300, 4'd3);
    add_row(qq_pkg::op_enq, 16'h0200, 4'd4);
    add_row(qq_pkg::op_enq, 16'h0100, 4'd5);
    add_row(qq_pkg::op_enq, 16'h0300, 4'd6);
    add_row(qq_pkg::op_nop, '0, 4'd6);
    for (int i = 0; i < 6; i++)
      add_row(qq_pkg::op_deq, '0, 4'(5 - i));
    // Random keys, interleaved, MSB first, 1 is an enqueue
    pat = 20'b1110_1011_1110_0100_0000;
    level = 0;
    for (int i = 0; i < 20; i++)
    begin
      if (pat[19])
      begin
        r = $random(seed);
        level++;
        add_row(qq_pkg::op_enq, r[`QQ_WIDTH-1:0], 4'(level));
      end
      else
      begin
        level--;
        add_row(qq_pkg::op_deq, '0, 4'(level));
      end
      pat = pat << 1;
    end
    add_row(qq_pkg::op_nop, '0, 4'd0);
  endtask

  // One row, driven on falling edges
  task automatic apply_row(input int idx);
    while (busy)
      @(negedge clk);
    entry_num   = 8'(idx);
    entry_op    = tbl_op[idx];
    entry_count = tbl_count[idx];
    if (tbl_op[idx] == qq_pkg::op_enq)
    begin
      data_in = tbl_key[idx];
      enq     = 1'b1;
    end
    else if (tbl_op[idx] == qq_pkg::op_deq)
      deq = 1'b1;
    @(negedge clk);
    enq = 1'b0;
    deq = 1'b0;
    // Fall of busy ends both kinds, out_valid comes inside it
    while (busy)
      @(negedge clk);
    entry_done = 1'b1;
    @(negedge clk);
    entry_done = 1'b0;
  endtask

  // Cycle budget covers the longest enqueue per row
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit)
    begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  initial
  begin
    rst         = 1'b1;
    enq         = 1'b0;
    deq         = 1'b0;
    data_in     = '0;
    entry_done  = 1'b0;
    entry_num   = '0;
    entry_op    = qq_pkg::op_nop;
    entry_count = '0;
    seed        = 45;
    build_table();
    cycle_limit = tbl_op.size() * (3 * `QQ_DEPTH + 4) + 50;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int i = 0; i < tbl_op.size(); i++)
      apply_row(i);
    // Checker counts settle before the rising edge
    @(posedge clk);
    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             tests, passes, tests - passes, errs);
    if (tests != tbl_op.size() + 1)
      $display("Checker closed %0d tests, table has %0d rows plus reset",
               tests, tbl_op.size());
    if (errs == 0 && tests == tbl_op.size() + 1)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+rtl
rtl/qq_pkg.sv
rtl/qq_ctrl_if.sv
rtl/qq_store.sv
rtl/qq_index.sv
rtl/qq_control.sv
rtl/quickq_top.sv
verif/qq_checker.sv
verif/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the quickq regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_top -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
